//--- acpi_green.f
hw/acpi_pkg.sv
hw/site_scanner.sv
hw/cross_window.sv
hw/green_estimator.sv
hw/acpi_green.sv
test/acpi_green_properties.sv
test/tb_acpi_green.sv

//--- run_sim.sh
#!/bin/sh
# Builds the acpi_green testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --top-module tb_acpi_green -f acpi_green.f -o tb_acpi_green
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_acpi_green > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log"; then
	exit 0
fi
echo "simulation failed, see $log"
exit 1

//--- test/acpi_input.txt
// words 0..143: 12x12 Bayer image, one row per line, green where row+col is even
// words 144..175: expected magnitude of 8x green per site in raster order (row, col)
08 3C 08 6E 08 28 08 32 08 5A 08 46
28 08 0A 08 3C 08 64 08 1E 08 00 08
08 5A 08 8C 08 46 08 50 08 78 08 64
32 08 14 08 46 08 6E 08 28 08 0A 08
08 46 08 78 08 32 08 3C 08 64 08 50
64 08 46 08 78 08 A0 08 5A 08 3C 08
08 28 08 5A 08 14 08 1E 08 46 08 32
50 08 32 08 64 08 8C 08 46 08 28 08
08 78 08 AA 08 64 08 6E 08 96 08 82
3C 08 1E 08 50 08 78 08 32 08 14 08
08 32 08 64 08 1E 08 28 08 50 08 3C
46 08 28 08 5A 08 82 08 3C 08 1E 08
00A4 // 2 3 vertical
00A4 // 2 5 vertical
0004 // 2 7 horizontal
00A4 // 2 9 vertical
0010 // 3 2 vertical, folded
0054 // 3 4 horizontal
0010 // 3 6 vertical, folded
0010 // 3 8 equal gradients, folded
0054 // 4 3 vertical
0054 // 4 5 vertical
0054 // 4 7 vertical
0054 // 4 9 vertical
00CC // 5 2 vertical
0054 // 5 4 horizontal
00CC // 5 6 vertical
0010 // 5 8 horizontal, folded
009C // 6 3 vertical, folded
0060 // 6 5 horizontal, folded
0004 // 6 7 horizontal
00B8 // 6 9 horizontal
0040 // 7 2 vertical
0040 // 7 4 vertical
0040 // 7 6 vertical
0040 // 7 8 vertical
0130 // 8 3 horizontal
0060 // 8 5 horizontal, folded
0004 // 8 7 horizontal
00B8 // 8 9 horizontal
0004 // 9 2 vertical
0054 // 9 4 horizontal
0004 // 9 6 vertical
0004 // 9 8 vertical

//--- test/tb_acpi_green.sv
// Testbench for the green interpolation core. A one-cycle pixel memory serves the
// Bayer image from the data file, and reads, results and finish are checked each cycle.
`timescale 1ns/1ps

module tb_acpi_green;

	logic            clk;
	logic            rst;
	logic            rd_en;
	acpi_pkg::addr_t rd_addr;
	acpi_pkg::pix_t  rd_data;
	logic            acpi_valid;
	acpi_pkg::addr_t acpi_addr;
	acpi_pkg::est_t  acpi_data;
	logic            finish;

	// image pixels first, expected results after them.
	logic [15:0]     file_words [acpi_pkg::img_w * acpi_pkg::img_h + acpi_pkg::site_count];
	logic            pending;
	acpi_pkg::addr_t pending_addr;
	int              cycle, read_count, out_count, last_valid, checks, errors, wait_count;

	acpi_green u_acpi_green (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.acpi_valid(acpi_valid), .acpi_addr(acpi_addr),
		.acpi_data(acpi_data), .finish(finish)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// expected values

	// k-th odd-parity interior pixel in raster order.
	function automatic acpi_pkg::addr_t site_address(input int k);
		int per_row;
		int row;
		int col;
		per_row = (acpi_pkg::img_w - 2 * acpi_pkg::border) / 2;
		row     = acpi_pkg::border + k / per_row;
		col     = acpi_pkg::border + (row + acpi_pkg::border + 1) % 2 + 2 * (k % per_row);
		return acpi_pkg::addr_t'(row * acpi_pkg::img_w + col);
	endfunction

	function automatic int tap_offset(input acpi_pkg::tap_e t);
		case (t)
			acpi_pkg::tap_w1: return -1;
			acpi_pkg::tap_e1: return 1;
			acpi_pkg::tap_n1: return -acpi_pkg::img_w;
			acpi_pkg::tap_s1: return acpi_pkg::img_w;
			acpi_pkg::tap_w2: return -2;
			acpi_pkg::tap_e2: return 2;
			acpi_pkg::tap_n2: return -2 * acpi_pkg::img_w;
			acpi_pkg::tap_s2: return 2 * acpi_pkg::img_w;
			default:          return 0;
		endcase
	endfunction

	function automatic acpi_pkg::est_t expected_est(input int k);
		return acpi_pkg::est_t'(file_words[8'(acpi_pkg::img_w * acpi_pkg::img_h + k)]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at cycle %0d: %s", cycle, msg);
	endtask

	task automatic check_addr(input string name, input acpi_pkg::addr_t got,
			input acpi_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic check_est(input string name, input acpi_pkg::est_t got,
			input acpi_pkg::est_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic check_idle(input string when);
		checks++;
		if (rd_en || acpi_valid || finish)
			report_error({"rd_en, acpi_valid or finish active ", when});
	endtask

	// advances one clock, answers the read and checks the outputs.
	task automatic step_cycle();
		acpi_pkg::tap_e tap;
		int             site;
		@(posedge clk);
		#1;
		cycle++;
		if (pending && int'(pending_addr) < acpi_pkg::img_w * acpi_pkg::img_h)
			rd_data = acpi_pkg::pix_t'(file_words[pending_addr]);
		else
			rd_data = '0;
		pending      = rd_en;
		pending_addr = rd_addr;
		if (rd_en) begin
			if (read_count >= acpi_pkg::site_count * acpi_pkg::tap_count) begin
				report_error("read strobe after the last site");
			end else begin
				tap  = acpi_pkg::tap_e'(4'(read_count % acpi_pkg::tap_count));
				site = read_count / acpi_pkg::tap_count;
				check_addr("rd_addr", rd_addr,
					acpi_pkg::addr_t'(int'(site_address(site)) + tap_offset(tap)));
			end
			read_count++;
		end else if (read_count < acpi_pkg::site_count * acpi_pkg::tap_count) begin
			report_error("read strobe missing before all reads were issued");
		end
		if (acpi_valid) begin
			if (out_count >= acpi_pkg::site_count) begin
				report_error("result after the last site");
			end else begin
				if (out_count > 0 && cycle - last_valid != acpi_pkg::tap_count)
					report_error($sformatf("result %0d cycles after the previous one",
						cycle - last_valid));
				check_addr("acpi_addr", acpi_addr, site_address(out_count));
				check_est("acpi_data", acpi_data, expected_est(out_count));
			end
			last_valid = cycle;
			out_count++;
		end
		if (finish != (out_count >= acpi_pkg::site_count))
			report_error($sformatf("finish is %0b after %0d results", finish, out_count));
	endtask

	initial begin
		rst          = 1'b1;
		rd_data      = '0;
		pending      = 1'b0;
		pending_addr = '0;
		cycle        = 0;
		read_count   = 0;
		out_count    = 0;
		last_valid   = 0;
		checks       = 0;
		errors       = 0;
		$readmemh("test/acpi_input.txt", file_words);
		repeat (10) begin
			@(posedge clk);
			#1;
			check_idle("during reset");
		end
		rst = 1'b0;
		check_idle("right after reset release");
		wait_count = 0;
		while (out_count < acpi_pkg::site_count &&
				wait_count < acpi_pkg::site_count * acpi_pkg::tap_count + 100) begin
			step_cycle();
			wait_count++;
		end
		if (out_count < acpi_pkg::site_count)
			report_error($sformatf("timeout waiting for results, %0d of %0d seen",
				out_count, acpi_pkg::site_count));
		else
			repeat (30) step_cycle(); // core must stay quiet after finish.
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- test/acpi_green_properties.sv
// Timing rules on the read and result ports of the green interpolation core.
// Attached to the top level by bind.
`timescale 1ns/1ps

module acpi_green_properties (
	input logic            clk,
	input logic            rst,
	input logic            rd_en,
	input acpi_pkg::addr_t rd_addr,
	input logic            acpi_valid,
	input logic            finish
);

	// never two results on consecutive cycles.
	assert property (@(posedge clk) disable iff (rst) acpi_valid |=> !acpi_valid)
		else $error("acpi_valid high on two consecutive cycles");

	assert property (@(posedge clk) disable iff (rst)
		rd_en |-> int'(rd_addr) < acpi_pkg::img_w * acpi_pkg::img_h)
		else $error("rd_addr outside the image");

	assert property (@(posedge clk) disable iff (rst) finish |-> !$rose(rd_en))
		else $error("rd_en rose after finish");

endmodule

bind acpi_green acpi_green_properties u_acpi_green_properties (
	.clk(clk), .rst(rst), .rd_en(rd_en), .rd_addr(rd_addr),
	.acpi_valid(acpi_valid), .finish(finish)
);

//--- hw/acpi_green.sv
// Top of the green interpolation core: scanner reads the pixel memory,
// the window gathers each cross and the estimator writes one result per site.
`timescale 1ns/1ps

module acpi_green (
	input  logic            clk,
	input  logic            rst,
	output logic            rd_en,
	output acpi_pkg::addr_t rd_addr,
	input  acpi_pkg::pix_t  rd_data,
	output logic            acpi_valid,
	output acpi_pkg::addr_t acpi_addr,
	output acpi_pkg::est_t  acpi_data,
	output logic            finish
);

	logic            cap_en, cap_last, win_valid, win_last;
	acpi_pkg::tap_e  cap_tap;
	acpi_pkg::addr_t cap_site, win_site;
	acpi_pkg::pix_t  c, w1, e1, n1, s1, w2, e2, n2, s2;

	site_scanner u_site_scanner (
		.clk(clk), .rst(rst),
		.rd_en(rd_en), .rd_addr(rd_addr),
		.cap_en(cap_en), .cap_tap(cap_tap),
		.cap_site(cap_site), .cap_last(cap_last)
	);

	cross_window u_cross_window (
		.clk(clk), .rst(rst),
		.cap_en(cap_en), .cap_tap(cap_tap),
		.cap_site(cap_site), .cap_last(cap_last),
		.rd_data(rd_data), .win_valid(win_valid),
		.c(c), .w1(w1), .e1(e1), .n1(n1), .s1(s1),
		.w2(w2), .e2(e2), .n2(n2), .s2(s2),
		.win_site(win_site), .win_last(win_last)
	);

	green_estimator u_green_estimator (
		.clk(clk), .rst(rst), .win_valid(win_valid),
		.c(c), .w1(w1), .e1(e1), .n1(n1), .s1(s1),
		.w2(w2), .e2(e2), .n2(n2), .s2(s2),
		.win_site(win_site), .win_last(win_last),
		.acpi_valid(acpi_valid), .acpi_addr(acpi_addr),
		.acpi_data(acpi_data), .finish(finish)
	);

endmodule

//--- hw/green_estimator.sv
// Picks the smoother direction from the cross gradients and registers the
// magnitude of eight times the interpolated green, with its site address.
`timescale 1ns/1ps

module green_estimator (
	input  logic            clk,
	input  logic            rst,
	input  logic            win_valid,
	input  acpi_pkg::pix_t  c, w1, e1, n1, s1, w2, e2, n2, s2,
	input  acpi_pkg::addr_t win_site,
	input  logic            win_last,
	output logic            acpi_valid,
	output acpi_pkg::addr_t acpi_addr,
	output acpi_pkg::est_t  acpi_data,
	output logic            finish
);

	typedef logic signed [acpi_pkg::est_w-1:0] sval_t;

	sval_t          xc, xw1, xe1, xn1, xs1, xw2, xe2, xn2, xs2;
	sval_t          dh, dv, est_h, est_v, est_b, est_sel;
	acpi_pkg::dir_e dir;

	function automatic sval_t ext(input acpi_pkg::pix_t p);
		return sval_t'({{(acpi_pkg::est_w - acpi_pkg::pix_w){1'b0}}, p});
	endfunction

	function automatic sval_t mag(input sval_t v);
		return (v < 0) ? -v : v;
	endfunction

	assign xc  = ext(c);
	assign xw1 = ext(w1);
	assign xe1 = ext(e1);
	assign xn1 = ext(n1);
	assign xs1 = ext(s1);
	assign xw2 = ext(w2);
	assign xe2 = ext(e2);
	assign xn2 = ext(n2);
	assign xs2 = ext(s2);

	//////////////////////////////////////////////////////////////////////
	// gradients and candidates

	assign dh = mag(xw1 - xe1) + mag((xc <<< 1) - xw2 - xe2);
	assign dv = mag(xn1 - xs1) + mag((xc <<< 1) - xn2 - xs2);

	assign est_h = ((xw1 + xe1) <<< 2) + (xc <<< 2) - ((xw2 + xe2) <<< 1);
	assign est_v = ((xn1 + xs1) <<< 2) + (xc <<< 2) - ((xn2 + xs2) <<< 1);
	assign est_b = ((xw1 + xe1 + xn1 + xs1) <<< 1) + (xc <<< 2)
		- (xw2 + xe2 + xn2 + xs2); // both directions at half weight.

	always_comb begin
		if (dh < dv)
			dir = acpi_pkg::dir_h;
		else if (dv < dh)
			dir = acpi_pkg::dir_v;
		else
			dir = acpi_pkg::dir_both;
	end

	always_comb begin
		case (dir)
			acpi_pkg::dir_h: est_sel = est_h;
			acpi_pkg::dir_v: est_sel = est_v;
			default:         est_sel = est_b;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// output register

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acpi_valid <= 1'b0;
			finish     <= 1'b0;
		end else begin
			acpi_valid <= win_valid;
			if (win_valid && win_last)
				finish <= 1'b1; // held until reset.
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			acpi_addr <= win_site;
			acpi_data <= acpi_pkg::est_t'(mag(est_sel)); // negative estimates fold.
		end
	end

endmodule

//--- hw/cross_window.sv
// Collects the nine returned pixels of a site into a cross and launches it
// with the site address once the last tap has arrived.
`timescale 1ns/1ps

module cross_window (
	input  logic            clk,
	input  logic            rst,
	input  logic            cap_en,
	input  acpi_pkg::tap_e  cap_tap,
	input  acpi_pkg::addr_t cap_site,
	input  logic            cap_last,
	input  acpi_pkg::pix_t  rd_data,
	output logic            win_valid,
	output acpi_pkg::pix_t  c, w1, e1, n1, s1, w2, e2, n2, s2,
	output acpi_pkg::addr_t win_site,
	output logic            win_last
);

	acpi_pkg::pix_t sh_c, sh_w1, sh_e1, sh_n1, sh_s1, sh_w2, sh_e2, sh_n2;
	logic           launch;

	assign launch = cap_en && cap_tap == acpi_pkg::tap_s2;

	// staging slots fill while the previous cross is still on the outputs.
	always_ff @(posedge clk) begin
		if (cap_en) begin
			case (cap_tap)
				acpi_pkg::tap_c:  sh_c  <= rd_data;
				acpi_pkg::tap_w1: sh_w1 <= rd_data;
				acpi_pkg::tap_e1: sh_e1 <= rd_data;
				acpi_pkg::tap_n1: sh_n1 <= rd_data;
				acpi_pkg::tap_s1: sh_s1 <= rd_data;
				acpi_pkg::tap_w2: sh_w2 <= rd_data;
				acpi_pkg::tap_e2: sh_e2 <= rd_data;
				acpi_pkg::tap_n2: sh_n2 <= rd_data;
				default: ; // s2 goes straight out.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			c        <= sh_c;
			w1       <= sh_w1;
			e1       <= sh_e1;
			n1       <= sh_n1;
			s1       <= sh_s1;
			w2       <= sh_w2;
			e2       <= sh_e2;
			n2       <= sh_n2;
			s2       <= rd_data;
			win_site <= cap_site;
			win_last <= cap_last;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			win_valid <= 1'b0;
		else
			win_valid <= launch;
	end

endmodule

//--- hw/site_scanner.sv
// Walks the interior sites in raster order and issues nine cross reads per site.
// Tags each read so the returning pixel can be placed a cycle later.
`timescale 1ns/1ps

module site_scanner (
	input  logic            clk,
	input  logic            rst,
	output logic            rd_en,
	output acpi_pkg::addr_t rd_addr,
	output logic            cap_en,
	output acpi_pkg::tap_e  cap_tap,
	output acpi_pkg::addr_t cap_site,
	output logic            cap_last
);

	acpi_pkg::addr_t row, col, site, tap_addr, rd_site;
	acpi_pkg::tap_e  tap, rd_tap;
	logic            rd_last, done, row_par, row_end, last_site;

	assign site      = row * acpi_pkg::addr_t'(acpi_pkg::img_w) + col;
	assign row_par   = row[0] ^ 1'(acpi_pkg::border % 2); // row starts on the margin column.
	assign row_end   = col >= acpi_pkg::addr_t'(acpi_pkg::img_w - acpi_pkg::border - 2);
	assign last_site = row_end && row == acpi_pkg::addr_t'(acpi_pkg::img_h - acpi_pkg::border - 1);

	always_comb begin
		case (tap)
			acpi_pkg::tap_w1: tap_addr = site - acpi_pkg::addr_t'(1);
			acpi_pkg::tap_e1: tap_addr = site + acpi_pkg::addr_t'(1);
			acpi_pkg::tap_n1: tap_addr = site - acpi_pkg::addr_t'(acpi_pkg::img_w);
			acpi_pkg::tap_s1: tap_addr = site + acpi_pkg::addr_t'(acpi_pkg::img_w);
			acpi_pkg::tap_w2: tap_addr = site - acpi_pkg::addr_t'(2);
			acpi_pkg::tap_e2: tap_addr = site + acpi_pkg::addr_t'(2);
			acpi_pkg::tap_n2: tap_addr = site - acpi_pkg::addr_t'(2 * acpi_pkg::img_w);
			acpi_pkg::tap_s2: tap_addr = site + acpi_pkg::addr_t'(2 * acpi_pkg::img_w);
			default:          tap_addr = site;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			row    <= acpi_pkg::addr_t'(acpi_pkg::border);
			col    <= acpi_pkg::addr_t'(acpi_pkg::border + 1); // first missing green.
			tap    <= acpi_pkg::tap_c;
			done   <= 1'b0;
			rd_en  <= 1'b0;
			cap_en <= 1'b0;
		end else begin
			cap_en <= rd_en; // data returns one cycle later.
			if (!done) begin
				rd_en <= 1'b1;
				if (tap == acpi_pkg::tap_e'(acpi_pkg::tap_count - 1)) begin
					tap <= acpi_pkg::tap_c;
					if (last_site) begin
						done <= 1'b1;
					end else if (row_end) begin
						row <= row + acpi_pkg::addr_t'(1);
						col <= acpi_pkg::addr_t'(row_par ? acpi_pkg::border + 1 : acpi_pkg::border);
					end else begin
						col <= col + acpi_pkg::addr_t'(2);
					end
				end else begin
					tap <= acpi_pkg::tap_e'(tap + 4'd1);
				end
			end else begin
				rd_en <= 1'b0;
			end
		end
	end

	// tags ride along with the strobe, then with the returned data.
	always_ff @(posedge clk) begin
		if (!done) begin
			rd_addr <= tap_addr;
			rd_tap  <= tap;
			rd_site <= site;
			rd_last <= last_site;
		end
		cap_tap  <= rd_tap;
		cap_site <= rd_site;
		cap_last <= rd_last;
	end

endmodule

//--- hw/acpi_pkg.sv
// Image geometry, widths and encodings for the Bayer green interpolation core.
// RTL and testbench reach these by scoped name.
package acpi_pkg;

	//////////////////////////////////////////////////////////////////////
	// image geometry

	localparam int img_w      = 12;
	localparam int img_h      = 12;
	localparam int border     = 2; // margin kept free of sites.
	localparam int site_count = 32; // odd-parity interior pixels.
	localparam int tap_count  = 9; // reads per site.

	//////////////////////////////////////////////////////////////////////
	// widths and types

	localparam int addr_w = 8; // row * img_w + col.
	localparam int pix_w  = 8;
	localparam int est_w  = 14; // holds 8x green and the signed sums.

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [pix_w-1:0]  pix_t;
	typedef logic [est_w-1:0]  est_t;

	// read order of the cross around a site.
	typedef enum logic [3:0] {
		tap_c  = 4'd0,
		tap_w1 = 4'd1,
		tap_e1 = 4'd2,
		tap_n1 = 4'd3,
		tap_s1 = 4'd4,
		tap_w2 = 4'd5,
		tap_e2 = 4'd6,
		tap_n2 = 4'd7,
		tap_s2 = 4'd8
	} tap_e;

	// which candidate estimate is taken.
	typedef enum logic [1:0] {
		dir_h    = 2'd0,
		dir_v    = 2'd1,
		dir_both = 2'd2
	} dir_e;

endpackage
